// File: common/mipsPkg.sv
/*
 * Word and register index widths, opcode and function encodings,
 * controller states and the two-view instruction word union
 */
`default_nettype none

package mipsPkg;

    // Machine word width
    localparam int dataWidth = 32;
    // Register index width, 32 general registers
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // Major opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcodeT;

    // Register format function codes in bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    // Controller sequence
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        MEMORY  = 2'd2,
        HALT    = 2'd3
    } cpuStateT;

    // Register format view
    typedef struct packed {
        opcodeT  opcode;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        logic [4:0] shamt;
        functT   funct;
    } rFormatT;

    // Immediate format view
    // J target is rs, rt and imm taken together
    typedef struct packed {
        opcodeT  opcode;
        regAddrT rs;
        regAddrT rt;
        logic [15:0] imm;
    } iFormatT;

    // Instruction register, decoded both ways
    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrU;

endpackage

`default_nettype wire

// File: common/regFilePortIf.sv
/*
 * Register file access bundle: two read ports and one write port
 */
`default_nettype none

interface regFilePortIf;
    import mipsPkg::*;

    // Read side, data comes back combinationally
    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT    rsData;
    wordT    rtData;

    // Write side, takes effect on the next edge
    logic    writeEnable;
    regAddrT writeAddr;
    wordT    writeData;

    modport controller (
        output rsAddr, rtAddr, writeEnable, writeAddr, writeData,
        input  rsData, rtData
    );

    modport regFile (
        input  rsAddr, rtAddr, writeEnable, writeAddr, writeData,
        output rsData, rtData
    );

    // Execute unit only looks at operands
    modport observer (
        input rsData, rtData
    );

endinterface

`default_nettype wire

// File: cpu/registerFile.sv
/*
 * General register file with hard-wired zero register and v0 tap
 */
`default_nettype none

module registerFile (
    input  logic           clk,
    input  logic           reset,
    regFilePortIf.regFile  port,
    output mipsPkg::wordT  v0
);
    import mipsPkg::*;

    // Registers 1 to 31, index 0 has no storage
    wordT regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (port.writeEnable && (port.writeAddr != '0)) begin
            // Writes to $zero fall away here
            regs[port.writeAddr] <= port.writeData;
        end
    end

    // Combinational reads
    // Index 0 forced to zero
    always_comb begin
        if (port.rsAddr == '0) begin
            port.rsData = '0;
        end else begin
            port.rsData = regs[port.rsAddr];
        end
    end

    always_comb begin
        if (port.rtAddr == '0) begin
            port.rtData = '0;
        end else begin
            port.rtData = regs[port.rtAddr];
        end
    end

    // Live $v0 for the top level
    assign v0 = regs[2];

endmodule

`default_nettype wire

// File: cpu/executeUnit.sv
/*
 * ALU, immediate extension, branch compare, effective address
 * and next-PC selection for the instruction register contents
 */
`default_nettype none

module executeUnit (
    input  mipsPkg::instrU    instr,
    input  mipsPkg::wordT     pc,
    regFilePortIf.observer    port,
    output mipsPkg::wordT     result,
    output mipsPkg::wordT     memAddress,
    output mipsPkg::wordT     nextPc,
    output mipsPkg::regAddrT  destReg,
    output logic              writesReg,
    output logic              isLoad,
    output logic              isStore
);
    import mipsPkg::*;

    wordT signImm;
    wordT zeroImm;
    wordT cmpOperand;
    wordT pcPlus4;
    wordT branchTarget;
    wordT jumpTarget;
    logic signedLess;
    logic unsignedLess;

    // Immediate extensions
    assign signImm = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign zeroImm = {16'b0, instr.i.imm};

    // SLT/SLTU compare rt, SLTI/SLTIU compare the sign-extended immediate
    assign cmpOperand   = (instr.r.opcode == OP_RTYPE) ? port.rtData : signImm;
    assign signedLess   = $signed(port.rsData) < $signed(cmpOperand);
    assign unsignedLess = port.rsData < cmpOperand;

    // Sequential and taken-branch targets, no delay slot
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[dataWidth-3:0], 2'b00};
    // Jump target field spans rs, rt and imm of the immediate view
    assign jumpTarget   = {pcPlus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};

    // Loads and stores are word only
    assign memAddress = port.rsData + signImm;

    always_comb begin
        result    = '0;
        destReg   = instr.i.rt;
        writesReg = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        nextPc    = pcPlus4;
        case (instr.r.opcode)
            OP_RTYPE: begin
                // Register format writes rd
                destReg   = instr.r.rd;
                writesReg = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: result = port.rsData + port.rtData;
                    FN_SUBU: result = port.rsData - port.rtData;
                    FN_AND:  result = port.rsData & port.rtData;
                    FN_OR:   result = port.rsData | port.rtData;
                    FN_XOR:  result = port.rsData ^ port.rtData;
                    FN_SLT:  result = wordT'(signedLess);
                    FN_SLTU: result = wordT'(unsignedLess);
                    // Constant shifts act on rt
                    FN_SLL:  result = port.rtData << instr.r.shamt;
                    FN_SRL:  result = port.rtData >> instr.r.shamt;
                    FN_SRA:  result = wordT'($signed(port.rtData) >>> instr.r.shamt);
                    FN_JR: begin
                        // JR $zero ends the program
                        writesReg = 1'b0;
                        nextPc    = port.rsData;
                    end
                    default: writesReg = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                writesReg = 1'b1;
                result    = port.rsData + signImm;
            end
            OP_SLTI: begin
                writesReg = 1'b1;
                result    = wordT'(signedLess);
            end
            OP_SLTIU: begin
                writesReg = 1'b1;
                result    = wordT'(unsignedLess);
            end
            // Logic immediates zero-extend
            OP_ANDI: begin
                writesReg = 1'b1;
                result    = port.rsData & zeroImm;
            end
            OP_ORI: begin
                writesReg = 1'b1;
                result    = port.rsData | zeroImm;
            end
            OP_XORI: begin
                writesReg = 1'b1;
                result    = port.rsData ^ zeroImm;
            end
            OP_LUI: begin
                writesReg = 1'b1;
                result    = {instr.i.imm, 16'b0};
            end
            OP_LW: begin
                // rt written later from read data
                writesReg = 1'b1;
                isLoad    = 1'b1;
            end
            OP_SW:  isStore = 1'b1;
            OP_BEQ: if (port.rsData == port.rtData) nextPc = branchTarget;
            OP_BNE: if (port.rsData != port.rtData) nextPc = branchTarget;
            OP_J:   nextPc = jumpTarget;
            // Unknown opcodes fall through as no-ops
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: cpu/cpuController.sv
/*
 * Fetch, execute and memory sequencing: PC, instruction register,
 * bus request registers and register file write steering
 */
`default_nettype none

module cpuController #(
    parameter mipsPkg::wordT resetVector
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               waitrequest,
    input  mipsPkg::wordT      readdata,
    input  mipsPkg::wordT      result,
    input  mipsPkg::wordT      memAddress,
    input  mipsPkg::wordT      nextPc,
    input  mipsPkg::regAddrT   destReg,
    input  logic               writesReg,
    input  logic               isLoad,
    input  logic               isStore,
    output mipsPkg::instrU     instr,
    output mipsPkg::wordT      pc,
    output mipsPkg::wordT      address,
    output mipsPkg::wordT      writedata,
    output logic               read,
    output logic               write,
    output logic               active,
    output logic [3:0]         byteenable,
    regFilePortIf.controller   port
);
    import mipsPkg::*;

    cpuStateT state;
    logic     busDone;
    logic     advance;
    logic     haltNext;

    // Request completes on the first edge without waitrequest
    assign busDone = (read || write) && !waitrequest;

    // Instruction retires: ALU/branch in EXECUTE, load/store at end of MEMORY
    assign advance = ((state == EXECUTE) && !isLoad && !isStore) ||
                     ((state == MEMORY) && busDone);

    // PC of zero stops the machine
    assign haltNext = (nextPc == '0);

    // Operand addresses straight from the instruction fields
    assign port.rsAddr = instr.r.rs;
    assign port.rtAddr = instr.r.rt;

    // Load data lands on the completing MEMORY edge, ALU results in EXECUTE
    assign port.writeAddr   = destReg;
    assign port.writeData   = (state == MEMORY) ? readdata : result;
    assign port.writeEnable = writesReg &&
        (((state == EXECUTE) && !isLoad) || ((state == MEMORY) && busDone));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH;
            pc         <= resetVector;
            address    <= resetVector;
            read       <= 1'b1;
            write      <= 1'b0;
            active     <= 1'b1;
            byteenable <= 4'b1111;
        end else if (advance) begin
            pc      <= nextPc;
            address <= nextPc;
            write   <= 1'b0;
            if (haltNext) begin
                // Parked until the next reset
                state  <= HALT;
                read   <= 1'b0;
                active <= 1'b0;
            end else begin
                state <= FETCH;
                read  <= 1'b1;
            end
        end else begin
            case (state)
                FETCH: begin
                    // Address held while stalled
                    if (busDone) begin
                        state <= EXECUTE;
                        read  <= 1'b0;
                    end
                end
                EXECUTE: begin
                    // Only loads and stores get here
                    state   <= MEMORY;
                    address <= memAddress;
                    read    <= isLoad;
                    write   <= isStore;
                end
                // MEMORY waits on busDone, HALT stays put
                default: ;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if ((state == FETCH) && busDone) begin
            instr <= readdata;
        end
        if ((state == EXECUTE) && isStore) begin
            writedata <= port.rtData;
        end
    end

endmodule

`default_nettype wire

// File: source/mipsCpuBus.sv
/*
 * CPU top level: controller, execute unit and register file on an Avalon master
 */
`default_nettype none

module mipsCpuBus #(
    parameter mipsPkg::wordT resetVector = 32'hBFC0_0000
) (
    input  logic           clk,
    input  logic           reset,
    output logic           active,
    output mipsPkg::wordT  register_v0,
    // Avalon master
    output mipsPkg::wordT  address,
    output logic           write,
    output logic           read,
    input  logic           waitrequest,
    output mipsPkg::wordT  writedata,
    output logic [3:0]     byteenable,
    input  mipsPkg::wordT  readdata
);
    import mipsPkg::*;

    // Controller to execute unit
    instrU   instr;
    wordT    pc;
    // Execute unit to controller
    wordT    result;
    wordT    memAddress;
    wordT    nextPc;
    regAddrT destReg;
    logic    writesReg;
    logic    isLoad;
    logic    isStore;

    regFilePortIf rfPort ();

    cpuController #(
        .resetVector (resetVector)
    ) controller (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .result      (result),
        .memAddress  (memAddress),
        .nextPc      (nextPc),
        .destReg     (destReg),
        .writesReg   (writesReg),
        .isLoad      (isLoad),
        .isStore     (isStore),
        .instr       (instr),
        .pc          (pc),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .active      (active),
        .byteenable  (byteenable),
        .port        (rfPort.controller)
    );

    executeUnit execute (
        .instr      (instr),
        .pc         (pc),
        .port       (rfPort.observer),
        .result     (result),
        .memAddress (memAddress),
        .nextPc     (nextPc),
        .destReg    (destReg),
        .writesReg  (writesReg),
        .isLoad     (isLoad),
        .isStore    (isStore)
    );

    registerFile registers (
        .clk   (clk),
        .reset (reset),
        .port  (rfPort.regFile),
        .v0    (register_v0)
    );

endmodule

`default_nettype wire

// File: dv/mipsCpuBusChecker.sv
/*
 * Bus protocol and halt assertions bound into the controller
 */
`default_nettype none

module mipsCpuBusChecker (
    input logic              clk,
    input logic              reset,
    input mipsPkg::cpuStateT state,
    input logic              read,
    input logic              write,
    input logic              waitrequest,
    input mipsPkg::wordT     address
);
    import mipsPkg::*;

    // Failed assertion count
    int failCount = 0;

    // Stalled request frozen until accepted
    property requestHeld;
        @(posedge clk) disable iff (reset)
            (read || write) && waitrequest |=>
                $stable(address) && $stable(read) && $stable(write);
    endproperty

    assert property (requestHeld)
        else begin
            failCount++;
            $error("Bus request changed while waitrequest was high");
        end

    // One direction at a time
    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            failCount++;
            $error("read and write high together");
        end

    // Halted CPU stays off the bus
    assert property (@(posedge clk) disable iff (reset) (state == HALT) |-> (!read && !write))
        else begin
            failCount++;
            $error("Bus request issued in HALT");
        end

endmodule

`default_nettype wire

// File: dv/mipsCpuBusTb.sv
/*
 * Random program generator, instruction-level model,
 * stalling memory responder, compare tasks and watchdog for the CPU
 */
`default_nettype none

module mipsCpuBusTb;
    import mipsPkg::*;

    localparam wordT resetVector = 32'hBFC0_0000;
    localparam int aluCount = 24;
    localparam int loadCount = 8;
    localparam int branchCount = 8;
    localparam int testCount = 5;
    // Word accesses enable every byte lane
    localparam logic [3:0] wordLanes = 4'b1111;

    logic       clk = 1'b0;
    logic       reset;
    logic       waitrequest;
    wordT       readdata;
    logic       active;
    logic       write;
    logic       read;
    wordT       register_v0;
    wordT       address;
    wordT       writedata;
    logic [3:0] byteenable;

    // Bus memory indexed by address bits 11:2
    // Program starts at index 0
    wordT mem [0:1023];
    // Model's own copy and register state
    wordT modelMem [0:1023];
    wordT modelRegs [0:31];

    logic [31:0] lfsr = 32'h9288;
    logic        modelDone = 1'b0;
    logic [1:0]  stall;
    logic [1:0]  stallLeft;
    int progLen;
    int totalInstr;
    int blockStart [0:4];
    int failedTests;

    // Expected bus traffic tagged with the test it belongs to
    wordT expReadAddr [$];
    int   expReadTest [$];
    wordT expWriteAddr [$];
    wordT expWriteData [$];
    int   expWriteTest [$];

    string testNames [0:4] = '{"reset", "alu", "loadStore", "controlFlow", "halt"};
    int testChecks [0:4] = '{default: 0};
    int testErrors [0:4] = '{default: 0};
    int checks = 0;
    int errors = 0;
    int finishedUpTo = -1;

    mipsCpuBus #(
        .resetVector (resetVector)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    bind cpuController mipsCpuBusChecker busChecker (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .address     (address)
    );

    always #2 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        logic outBit;
        value = '0;
        for (int k = 0; k < count; k++) begin
            outBit = lfsr[0];
            lfsr = lfsr >> 1;
            if (outBit) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    function automatic int wordIndex(input wordT addr);
        return int'(addr[11:2]);
    endfunction

    function automatic wordT encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] rd, input logic [4:0] sh,
                                     input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT encodeI(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Test block that holds a given program word
    function automatic int testOf(input int idx);
        int t;
        t = 1;
        for (int k = 2; k <= 4; k++) begin
            if (idx >= blockStart[k]) begin
                t = k;
            end
        end
        return t;
    endfunction

    task automatic emitWord(input wordT word);
        mem[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        int rFuncts [0:9];
        int iOps [0:6];
        int kind;
        logic [4:0] dest;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
        wordT target;
        // ADDU SUBU AND OR XOR SLT SLTU then SLL SRL SRA
        rFuncts = '{33, 35, 36, 37, 38, 42, 43, 0, 2, 3};
        // ADDIU ANDI ORI XORI LUI SLTI SLTIU
        iOps = '{9, 12, 13, 14, 15, 10, 11};
        progLen = 0;
        blockStart[0] = 0;
        blockStart[1] = 0;
        // ALU op followed by a store of its destination
        for (int k = 0; k < aluCount; k++) begin
            kind = int'(takeBits(5)) % 17;
            dest = 5'(takeBits(5));
            rs   = 5'(takeBits(5));
            rt   = 5'(takeBits(5));
            imm  = 16'(takeBits(16));
            if (kind < 10) begin
                emitWord(encodeR(rs, rt, dest, (kind >= 7) ? imm[4:0] : 5'd0,
                                 6'(rFuncts[kind])));
            end else begin
                emitWord(encodeI(6'(iOps[kind - 10]), rs, dest, imm));
            end
            emitWord(encodeI(6'd43, 5'd0, dest, 16'h0800 + 16'(4 * k)));
        end
        // Load a preloaded word and store it elsewhere
        blockStart[2] = progLen;
        for (int k = 0; k < loadCount; k++) begin
            mem[wordIndex(32'h900 + 32'(4 * k))] = takeBits(32);
            dest = 5'(takeBits(5));
            if (dest == 5'd0) begin
                dest = 5'd1;
            end
            emitWord(encodeI(6'd35, 5'd0, dest, 16'h0900 + 16'(4 * k)));
            emitWord(encodeI(6'd43, 5'd0, dest, 16'h0A00 + 16'(4 * k)));
        end
        // Branch or jump over one filler word
        blockStart[3] = progLen;
        for (int k = 0; k < branchCount; k++) begin
            kind = int'(takeBits(2));
            rs = 5'(takeBits(5));
            rt = takeBits(1) ? rs : 5'(takeBits(5));
            if (kind == 2) begin
                target = resetVector + 32'(4 * (progLen + 2));
                emitWord({6'd2, target[27:2]});
            end else begin
                emitWord(encodeI((kind == 1) ? 6'd5 : 6'd4, rs, rt, 16'd1));
            end
            // Filler shows up in v0 only when not skipped
            emitWord(encodeI(6'd9, 5'd2, 5'd2, 16'(takeBits(16))));
        end
        // JR $zero ends the run
        blockStart[4] = progLen;
        emitWord(encodeR(5'd0, 5'd0, 5'd0, 5'd0, 6'd8));
    endtask

    // Runs the program one instruction at a time and records bus traffic
    task automatic runModel();
        wordT pc;
        wordT instr;
        wordT a;
        wordT b;
        wordT se;
        wordT ze;
        wordT next;
        wordT value;
        wordT addr;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sh;
        logic [4:0] dest;
        logic [5:0] op;
        logic [5:0] fn;
        logic wr;
        int tag;
        for (int i = 0; i < 1024; i++) begin
            modelMem[i] = mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        pc = resetVector;
        totalInstr = 0;
        while (pc != '0 && totalInstr < 4096) begin
            instr = modelMem[wordIndex(pc)];
            tag = testOf(wordIndex(pc));
            expReadAddr.push_back(pc);
            expReadTest.push_back(tag);
            op = instr[31:26];
            rs = instr[25:21];
            rt = instr[20:16];
            rd = instr[15:11];
            sh = instr[10:6];
            fn = instr[5:0];
            se = {{16{instr[15]}}, instr[15:0]};
            ze = {16'h0, instr[15:0]};
            a = modelRegs[rs];
            b = modelRegs[rt];
            next = pc + 32'd4;
            wr = 1'b0;
            dest = rt;
            value = '0;
            case (op)
                6'd0: begin
                    dest = rd;
                    wr = 1'b1;
                    case (fn)
                        6'd33: value = a + b;
                        6'd35: value = a - b;
                        6'd36: value = a & b;
                        6'd37: value = a | b;
                        6'd38: value = a ^ b;
                        6'd42: value = {31'd0, $signed(a) < $signed(b)};
                        6'd43: value = {31'd0, a < b};
                        6'd0:  value = b << sh;
                        6'd2:  value = b >> sh;
                        6'd3:  value = $signed(b) >>> sh;
                        6'd8: begin
                            wr = 1'b0;
                            next = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                6'd9: begin
                    wr = 1'b1;
                    value = a + se;
                end
                6'd10: begin
                    wr = 1'b1;
                    value = {31'd0, $signed(a) < $signed(se)};
                end
                6'd11: begin
                    wr = 1'b1;
                    value = {31'd0, a < se};
                end
                6'd12: begin
                    wr = 1'b1;
                    value = a & ze;
                end
                6'd13: begin
                    wr = 1'b1;
                    value = a | ze;
                end
                6'd14: begin
                    wr = 1'b1;
                    value = a ^ ze;
                end
                6'd15: begin
                    wr = 1'b1;
                    value = {instr[15:0], 16'h0};
                end
                6'd35: begin
                    addr = a + se;
                    expReadAddr.push_back(addr);
                    expReadTest.push_back(tag);
                    wr = 1'b1;
                    value = modelMem[wordIndex(addr)];
                end
                6'd43: begin
                    addr = a + se;
                    expWriteAddr.push_back(addr);
                    expWriteData.push_back(b);
                    expWriteTest.push_back(tag);
                    modelMem[wordIndex(addr)] = b;
                end
                // No delay slot so the target follows directly
                6'd4: if (a == b) next = pc + 32'd4 + {se[29:0], 2'b00};
                6'd5: if (a != b) next = pc + 32'd4 + {se[29:0], 2'b00};
                6'd2: next = {next[31:28], instr[25:0], 2'b00};
                default: ;
            endcase
            if (wr && dest != 5'd0) begin
                modelRegs[dest] = value;
            end
            pc = next;
            totalInstr++;
        end
    endtask

    task automatic checkWord(input int test, input string what,
                             input wordT expected, input wordT actual);
        checks++;
        testChecks[test]++;
        if (actual !== expected) begin
            errors++;
            testErrors[test]++;
            $display("FAIL %s %s: expected %h, actual %h",
                     testNames[test], what, expected, actual);
        end
    endtask

    task automatic checkBit(input int test, input string what,
                            input logic expected, input logic actual);
        checks++;
        testChecks[test]++;
        if (actual !== expected) begin
            errors++;
            testErrors[test]++;
            $display("FAIL %s %s: expected %b, actual %b",
                     testNames[test], what, expected, actual);
        end
    endtask

    task automatic checkLanes(input int test, input string what,
                              input logic [3:0] expected, input logic [3:0] actual);
        checks++;
        testChecks[test]++;
        if (actual !== expected) begin
            errors++;
            testErrors[test]++;
            $display("FAIL %s %s: expected %b, actual %b",
                     testNames[test], what, expected, actual);
        end
    endtask

    task automatic reportTest(input int test);
        $display("Test %s done: %0d checks, %0d errors",
                 testNames[test], testChecks[test], testErrors[test]);
    endtask

    task automatic completeRead();
        wordT expected;
        int tag;
        if (expReadAddr.size() == 0) begin
            errors++;
            testErrors[4]++;
            $display("Read request at %h after the program should have ended", address);
        end else begin
            expected = expReadAddr.pop_front();
            tag = expReadTest.pop_front();
            // First fetch of a new block closes the previous ones
            for (int t = finishedUpTo + 1; t < tag; t++) begin
                reportTest(t);
            end
            if (tag - 1 > finishedUpTo) begin
                finishedUpTo = tag - 1;
            end
            checkWord(tag, "read address", expected, address);
            checkLanes(tag, "read byteenable", wordLanes, byteenable);
        end
    endtask

    task automatic completeWrite();
        int tag;
        if (expWriteAddr.size() == 0) begin
            errors++;
            testErrors[4]++;
            $display("Write request at %h that the program never issues", address);
        end else begin
            tag = expWriteTest.pop_front();
            checkWord(tag, "write address", expWriteAddr.pop_front(), address);
            checkWord(tag, "write data", expWriteData.pop_front(), writedata);
            checkLanes(tag, "write byteenable", wordLanes, byteenable);
        end
        mem[wordIndex(address)] = writedata;
    endtask

    // Memory responder with 0 to 3 stall cycles per request
    always @(posedge clk) begin
        if (!reset && (read || write)) begin
            if (!waitrequest) begin
                if (read) begin
                    completeRead();
                end else begin
                    completeWrite();
                end
                // Stall for whichever request comes next
                stall = 2'(takeBits(2));
                stallLeft <= stall;
                waitrequest <= (stall != 2'd0);
            end else begin
                stallLeft <= stallLeft - 2'd1;
                waitrequest <= (stallLeft > 2'd1);
            end
        end
        // Data for the next expected read stays valid until it completes
        if (expReadAddr.size() > 0) begin
            readdata <= mem[wordIndex(expReadAddr[0])];
        end else begin
            readdata <= '0;
        end
    end

    initial begin
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        stallLeft = 2'd0;
        // Unused words carry an address-dependent pattern
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hC0DE_0000 ^ (32'(i) * 32'h0001_0003);
        end
        buildProgram();
        runModel();
        modelDone = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkBit(0, "active after reset", 1'b1, active);
        checkBit(0, "read after reset", 1'b1, read);
        checkBit(0, "write after reset", 1'b0, write);
        checkWord(0, "first address", resetVector, address);
        reportTest(0);
        finishedUpTo = 0;
        while (active !== 1'b0) begin
            @(negedge clk);
        end
        // Bus stays quiet once halted
        repeat (8) begin
            @(negedge clk);
            checkBit(4, "read after halt", 1'b0, read);
            checkBit(4, "write after halt", 1'b0, write);
        end
        checkBit(4, "active after halt", 1'b0, active);
        checkWord(4, "register v0", modelRegs[2], register_v0);
        if (expReadAddr.size() != 0 || expWriteAddr.size() != 0) begin
            errors++;
            testErrors[4]++;
            $display("CPU halted with %0d reads and %0d writes still outstanding",
                     expReadAddr.size(), expWriteAddr.size());
        end
        // Protocol assertions bound into the controller
        if (UUT.controller.busChecker.failCount != 0) begin
            errors++;
            $display("Bus protocol assertions failed %0d times",
                     UUT.controller.busChecker.failCount);
        end
        for (int t = finishedUpTo + 1; t < testCount; t++) begin
            reportTest(t);
        end
        failedTests = 0;
        for (int t = 0; t < testCount; t++) begin
            if (testErrors[t] != 0) begin
                failedTests++;
            end
        end
        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 testCount, failedTests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the model's instruction count
    initial begin
        wait (modelDone === 1'b1);
        #((totalInstr * 8 + 50) * 4);
        $display("Watchdog expired, CPU did not halt within the time for %0d instructions",
                 totalInstr);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/mipsPkg.sv
common/regFilePortIf.sv
cpu/registerFile.sv
cpu/executeUnit.sv
cpu/cpuController.sv
source/mipsCpuBus.sv
dv/mipsCpuBusChecker.sv
dv/mipsCpuBusTb.sv
